/* compile.f */
hdl/cpu_pkg.sv
hdl/if_id_if.sv
hdl/imem_apb.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/frontend_top.sv
tests/frontend_asserts.sv
tests/tb_frontend.sv

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // Datapath widths
    localparam int ADDR_BITS   = 32;
    localparam int DATA_BITS   = 32;
    localparam int BRANCH_BITS = 2;

    // Branch control from execute
    localparam logic [BRANCH_BITS-1:0] BRANCH_NEXT = 2'd0;
    localparam logic [BRANCH_BITS-1:0] BRANCH_BEQ  = 2'd1;
    localparam logic [BRANCH_BITS-1:0] BRANCH_JAL  = 2'd2;
    localparam logic [BRANCH_BITS-1:0] BRANCH_JALR = 2'd3;

    // RV32I major opcodes seen by decode
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // ID/EX record
    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] pc;
        logic [6:0]           opcode;
        logic [4:0]           rd;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        logic [DATA_BITS-1:0] imm;
    } decoded_t;

endpackage

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              run_i,
    input  logic              stall_i,
    input  logic              flush_i,
    if_id_if.decode           if2id,
    output cpu_pkg::decoded_t id_o
);

    logic [cpu_pkg::DATA_BITS-1:0] inst;
    logic [6:0]                    opcode;
    logic [cpu_pkg::DATA_BITS-1:0] imm_i;
    logic [cpu_pkg::DATA_BITS-1:0] imm_s;
    logic [cpu_pkg::DATA_BITS-1:0] imm_b;
    logic [cpu_pkg::DATA_BITS-1:0] imm_u;
    logic [cpu_pkg::DATA_BITS-1:0] imm_j;
    logic [cpu_pkg::DATA_BITS-1:0] imm;
    cpu_pkg::decoded_t             dec;
    cpu_pkg::decoded_t             id_q;

    assign inst   = if2id.inst;
    assign opcode = inst[6:0];

    // Sign-extended immediate for each format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            cpu_pkg::OP_IMM,
            cpu_pkg::OP_LOAD,
            cpu_pkg::OP_JALR:   imm = imm_i;
            cpu_pkg::OP_STORE:  imm = imm_s;
            cpu_pkg::OP_BRANCH: imm = imm_b;
            cpu_pkg::OP_LUI,
            cpu_pkg::OP_AUIPC:  imm = imm_u;
            cpu_pkg::OP_JAL:    imm = imm_j;
            // R-type and anything unknown carry no immediate
            default:            imm = '0;
        endcase
    end

    // Register fields sit at fixed positions in every format
    always_comb begin
        dec.valid  = if2id.valid;
        dec.pc     = if2id.pc;
        dec.opcode = opcode;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.funct3 = inst[14:12];
        dec.funct7 = inst[31:25];
        dec.imm    = imm;
    end

    // ID/EX register on the same enable as fetch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_q <= '0;
        end else if (run_i) begin
            if (flush_i) begin
                id_q <= '0;
            end else if (!stall_i) begin
                id_q <= dec;
            end
        end
    end

    assign id_o = id_q;

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter logic [cpu_pkg::ADDR_BITS-1:0] RESET_PC = '0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            run_i,
    input  logic                            stall_i,
    input  logic                            flush_i,
    input  logic [cpu_pkg::DATA_BITS-1:0]   inst_i,
    output logic [cpu_pkg::ADDR_BITS-1:0]   inst_pc_o,
    // Branch resolution from execute
    input  logic [cpu_pkg::BRANCH_BITS-1:0] branch_ctrl_i,
    input  logic                            zero_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   pc_imm_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   pc_aluout_i,
    // CSR redirects
    input  logic                            csr_int_i,
    input  logic                            csr_mret_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   csr_pc_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   csr_retpc_i,
    if_id_if.fetch                          if2id
);

    logic [cpu_pkg::ADDR_BITS-1:0] pc_q;
    logic [cpu_pkg::ADDR_BITS-1:0] pc_plus4;
    logic [cpu_pkg::ADDR_BITS-1:0] pc_next;
    logic                          advance;

    assign pc_plus4  = pc_q + 32'd4;
    assign inst_pc_o = pc_q;
    assign advance   = run_i && !stall_i;

    // mret beats interrupt and both beat execute
    always_comb begin
        if (csr_mret_i) begin
            pc_next = csr_retpc_i;
        end else if (csr_int_i) begin
            pc_next = csr_pc_i;
        end else begin
            case (branch_ctrl_i)
                cpu_pkg::BRANCH_NEXT: pc_next = pc_plus4;
                // zero_i high means the operands differ
                cpu_pkg::BRANCH_BEQ:  pc_next = zero_i ? pc_plus4 : pc_imm_i;
                cpu_pkg::BRANCH_JAL:  pc_next = pc_imm_i;
                cpu_pkg::BRANCH_JALR: pc_next = {pc_aluout_i[31:1], 1'b0};
                default:              pc_next = pc_plus4;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (advance) begin
            pc_q <= pc_next;
        end
    end

    // IF/ID register where flush wins over stall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if2id.pc    <= '0;
            if2id.inst  <= '0;
            if2id.valid <= 1'b0;
        end else if (run_i) begin
            if (flush_i) begin
                if2id.pc    <= '0;
                if2id.inst  <= '0;
                if2id.valid <= 1'b0;
            end else if (!stall_i) begin
                if2id.pc    <= pc_q;
                if2id.inst  <= inst_i;
                if2id.valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter int                            IMEM_WORDS = 256,
    parameter logic [cpu_pkg::ADDR_BITS-1:0] RESET_PC   = '0
) (
    input  logic                            clk,
    input  logic                            rst,
    // APB slave for program load
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   paddr_i,
    input  logic [cpu_pkg::DATA_BITS-1:0]   pwdata_i,
    output logic [cpu_pkg::DATA_BITS-1:0]   prdata_o,
    output logic                            pready_o,
    // Pipeline control
    input  logic                            run_i,
    input  logic                            stall_i,
    input  logic                            flush_i,
    // Execute and CSR redirects
    input  logic [cpu_pkg::BRANCH_BITS-1:0] branch_ctrl_i,
    input  logic                            zero_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   pc_imm_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   pc_aluout_i,
    input  logic                            csr_int_i,
    input  logic                            csr_mret_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   csr_pc_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0]   csr_retpc_i,
    output logic [cpu_pkg::ADDR_BITS-1:0]   inst_pc_o,
    // Decoded instruction
    output logic                            id_valid_o,
    output logic [cpu_pkg::ADDR_BITS-1:0]   id_pc_o,
    output logic [6:0]                      id_opcode_o,
    output logic [4:0]                      id_rd_o,
    output logic [4:0]                      id_rs1_o,
    output logic [4:0]                      id_rs2_o,
    output logic [2:0]                      id_funct3_o,
    output logic [6:0]                      id_funct7_o,
    output logic [cpu_pkg::DATA_BITS-1:0]   id_imm_o
);

    logic [cpu_pkg::DATA_BITS-1:0] fetch_inst;
    cpu_pkg::decoded_t             id_rec;

    if_id_if u_if2id ();

    imem_apb #(
        .IMEM_WORDS(IMEM_WORDS)
    ) u_imem (
        .clk         (clk),
        .rst         (rst),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .fetch_addr_i(inst_pc_o),
        .fetch_inst_o(fetch_inst)
    );

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst          (rst),
        .run_i        (run_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .inst_i       (fetch_inst),
        .inst_pc_o    (inst_pc_o),
        .branch_ctrl_i(branch_ctrl_i),
        .zero_i       (zero_i),
        .pc_imm_i     (pc_imm_i),
        .pc_aluout_i  (pc_aluout_i),
        .csr_int_i    (csr_int_i),
        .csr_mret_i   (csr_mret_i),
        .csr_pc_i     (csr_pc_i),
        .csr_retpc_i  (csr_retpc_i),
        .if2id        (u_if2id.fetch)
    );

    decode_stage u_decode (
        .clk    (clk),
        .rst    (rst),
        .run_i  (run_i),
        .stall_i(stall_i),
        .flush_i(flush_i),
        .if2id  (u_if2id.decode),
        .id_o   (id_rec)
    );

    // Flatten the ID/EX record
    assign id_valid_o  = id_rec.valid;
    assign id_pc_o     = id_rec.pc;
    assign id_opcode_o = id_rec.opcode;
    assign id_rd_o     = id_rec.rd;
    assign id_rs1_o    = id_rec.rs1;
    assign id_rs2_o    = id_rec.rs2;
    assign id_funct3_o = id_rec.funct3;
    assign id_funct7_o = id_rec.funct7;
    assign id_imm_o    = id_rec.imm;

endmodule

`default_nettype wire

/* hdl/if_id_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface if_id_if;

    // IF/ID pipeline register contents
    logic [cpu_pkg::ADDR_BITS-1:0] pc;
    logic [cpu_pkg::DATA_BITS-1:0] inst;
    logic                          valid;

    modport fetch (
        output pc,
        output inst,
        output valid
    );

    modport decode (
        input pc,
        input inst,
        input valid
    );

endinterface

`default_nettype wire

/* hdl/imem_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_apb #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    // APB slave
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [cpu_pkg::ADDR_BITS-1:0] paddr_i,
    input  logic [cpu_pkg::DATA_BITS-1:0] pwdata_i,
    output logic [cpu_pkg::DATA_BITS-1:0] prdata_o,
    output logic                          pready_o,
    // Fetch read port
    input  logic [cpu_pkg::ADDR_BITS-1:0] fetch_addr_i,
    output logic [cpu_pkg::DATA_BITS-1:0] fetch_inst_o
);

    localparam int IDX_BITS = $clog2(IMEM_WORDS);

    logic [cpu_pkg::DATA_BITS-1:0] mem [IMEM_WORDS];

    logic                access;
    logic                wr_en;
    logic [IDX_BITS-1:0] apb_idx;
    logic [IDX_BITS-1:0] fetch_idx;

    // Access phase of a transfer
    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i;

    // Word index with the byte offset dropped
    assign apb_idx   = paddr_i[IDX_BITS+1:2];
    assign fetch_idx = fetch_addr_i[IDX_BITS+1:2];

    // Zero wait state slave
    assign pready_o = access;

    always_comb begin
        if (access && !pwrite_i) begin
            prdata_o = mem[apb_idx];
        end else begin
            prdata_o = '0;
        end
    end

    // Words clear on reset and load over APB
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < IMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[apb_idx] <= pwdata_i;
        end
    end

    // Asynchronous read for the fetch stage
    assign fetch_inst_o = mem[fetch_idx];

endmodule

`default_nettype wire

/* tests/frontend_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_asserts (
    input logic                          clk,
    input logic                          rst,
    input logic                          run_i,
    input logic                          stall_i,
    input logic                          flush_i,
    input logic [cpu_pkg::ADDR_BITS-1:0] inst_pc_i,
    input logic [cpu_pkg::DATA_BITS-1:0] if_inst_i,
    input logic                          if_valid_i
);

    // Number of failed assertions so far
    int fail_count = 0;

    // Fetch address never odd
    pc_aligned: assert property (@(posedge clk) disable iff (rst) inst_pc_i[0] == 1'b0)
        else begin
            $error("fetch PC has bit 0 set: %h", inst_pc_i);
            fail_count++;
        end

    // PC register holds across a stalled edge
    stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        (run_i && stall_i) |=> $stable(inst_pc_i))
        else begin
            $error("fetch PC moved across a stalled edge");
            fail_count++;
        end

    // IF/ID bubble after a flushed edge
    flush_clears_if_id: assert property (@(posedge clk) disable iff (rst)
        (run_i && flush_i) |=> (if_inst_i == '0 && !if_valid_i))
        else begin
            $error("IF/ID not cleared after flush: inst %h valid %b", if_inst_i, if_valid_i);
            fail_count++;
        end

endmodule

bind fetch_stage frontend_asserts u_fetch_asserts (
    .clk       (clk),
    .rst       (rst),
    .run_i     (run_i),
    .stall_i   (stall_i),
    .flush_i   (flush_i),
    .inst_pc_i (inst_pc_o),
    .if_inst_i (if2id.inst),
    .if_valid_i(if2id.valid)
);

`default_nettype wire

/* tests/tb_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

    localparam int MEM_WORDS   = 256;
    localparam int APB_TIMEOUT = 20;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel, penable, pwrite, pready;
    logic [31:0] paddr, pwdata, prdata;
    logic        run, stall, flush, zero, csr_int, csr_mret;
    logic [1:0]  branch_ctrl;
    logic [31:0] pc_imm, pc_aluout, csr_pc, csr_retpc, inst_pc;
    logic        id_valid;
    logic [31:0] id_pc, id_imm;
    logic [6:0]  id_opcode, id_funct7;
    logic [4:0]  id_rd, id_rs1, id_rs2;
    logic [2:0]  id_funct3;

    // Reference model with entry 0 as IF/ID and entry 1 as ID/EX
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] model_pc;
    logic [31:0] pipe_pc [2];
    logic [31:0] pipe_inst [2];
    logic        pipe_valid [2];

    logic [31:0] rng_state;
    string       cur_test;
    int          test_errs, test_checks, tests_ok, tests_bad;

    frontend_top #(
        .IMEM_WORDS(MEM_WORDS),
        .RESET_PC  (32'h0)
    ) u_frontend_top (
        .clk(clk), .rst(rst),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .run_i(run), .stall_i(stall), .flush_i(flush),
        .branch_ctrl_i(branch_ctrl), .zero_i(zero),
        .pc_imm_i(pc_imm), .pc_aluout_i(pc_aluout),
        .csr_int_i(csr_int), .csr_mret_i(csr_mret),
        .csr_pc_i(csr_pc), .csr_retpc_i(csr_retpc), .inst_pc_o(inst_pc),
        .id_valid_o(id_valid), .id_pc_o(id_pc), .id_opcode_o(id_opcode),
        .id_rd_o(id_rd), .id_rs1_o(id_rs1), .id_rs2_o(id_rs2),
        .id_funct3_o(id_funct3), .id_funct7_o(id_funct7), .id_imm_o(id_imm)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Field bits packed at the top and shifted down arithmetically
    function automatic logic [31:0] imm_for_format(input logic [31:0] inst);
        logic [31:0] bits;
        int          shift;
        bits  = '0;
        shift = 0;
        case (inst[6:0])
            cpu_pkg::OP_IMM, cpu_pkg::OP_LOAD, cpu_pkg::OP_JALR: begin
                bits  = {inst[31:20], 20'b0};
                shift = 20;
            end
            cpu_pkg::OP_STORE: begin
                bits  = {inst[31:25], inst[11:7], 20'b0};
                shift = 20;
            end
            cpu_pkg::OP_BRANCH: begin
                bits  = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0, 19'b0};
                shift = 19;
            end
            cpu_pkg::OP_LUI, cpu_pkg::OP_AUIPC: bits = {inst[31:12], 12'b0};
            cpu_pkg::OP_JAL: begin
                bits  = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0, 11'b0};
                shift = 11;
            end
            default: bits = '0;
        endcase
        return $unsigned($signed(bits) >>> shift);
    endfunction

    function automatic logic [31:0] next_pc_rule();
        if (csr_mret) return csr_retpc;
        if (csr_int) return csr_pc;
        case (branch_ctrl)
            cpu_pkg::BRANCH_BEQ:  return zero ? model_pc + 32'd4 : pc_imm;
            cpu_pkg::BRANCH_JAL:  return pc_imm;
            cpu_pkg::BRANCH_JALR: return pc_aluout & ~32'd1;
            default:              return model_pc + 32'd4;
        endcase
    endfunction

    function automatic logic [6:0] opcode_at(input int n);
        case (n)
            0: return cpu_pkg::OP_LUI;
            1: return cpu_pkg::OP_AUIPC;
            2: return cpu_pkg::OP_JAL;
            3: return cpu_pkg::OP_JALR;
            4: return cpu_pkg::OP_BRANCH;
            5: return cpu_pkg::OP_LOAD;
            6: return cpu_pkg::OP_STORE;
            7: return cpu_pkg::OP_IMM;
            8: return cpu_pkg::OP_REG;
            default: return 7'h7f;
        endcase
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        if (actual !== expected) begin
            test_errs++;
            $display("[FAIL] %s %s: expected %h actual %h", cur_test, field, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            tests_ok++;
            $display("test %s: ok, %0d checks", cur_test, test_checks);
        end else begin
            tests_bad++;
            $display("test %s: %0d of %0d checks wrong", cur_test, test_errs, test_checks);
        end
    endtask

    task automatic quiet_controls();
        stall       = 1'b0;
        flush       = 1'b0;
        branch_ctrl = cpu_pkg::BRANCH_NEXT;
        zero        = 1'b0;
        pc_imm      = '0;
        pc_aluout   = '0;
        csr_int     = 1'b0;
        csr_mret    = 1'b0;
        csr_pc      = '0;
        csr_retpc   = '0;
    endtask

    // Starts and ends on a falling edge
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        check_value("pready in setup", 32'h0, pready);
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (!pready) begin
            if (waited >= APB_TIMEOUT) begin
                $display("APB transfer to %h never completed, pready stayed low", addr);
                $display("TB FAILED");
                $finish;
            end
            waited++;
            @(posedge clk);
        end
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Step the model on the driven inputs and compare once the edge has settled
    task automatic clock_and_check();
        logic [31:0] pc_after;
        logic [31:0] inst;
        pc_after = model_pc;
        if (run && !stall) begin
            pc_after = next_pc_rule();
        end
        if (run && flush) begin
            for (int s = 0; s < 2; s++) begin
                pipe_pc[s]    = '0;
                pipe_inst[s]  = '0;
                pipe_valid[s] = 1'b0;
            end
        end else if (run && !stall) begin
            pipe_pc[1]    = pipe_pc[0];
            pipe_inst[1]  = pipe_inst[0];
            pipe_valid[1] = pipe_valid[0];
            pipe_pc[0]    = model_pc;
            pipe_inst[0]  = model_mem[(model_pc >> 2) % MEM_WORDS];
            pipe_valid[0] = 1'b1;
        end
        model_pc = pc_after;
        @(posedge clk);
        @(negedge clk);
        inst = pipe_inst[1];
        check_value("inst_pc", model_pc, inst_pc);
        check_value("id_valid", pipe_valid[1], id_valid);
        check_value("id_pc", pipe_pc[1], id_pc);
        check_value("id_opcode", inst[6:0], id_opcode);
        check_value("id_rd", inst[11:7], id_rd);
        check_value("id_rs1", inst[19:15], id_rs1);
        check_value("id_rs2", inst[24:20], id_rs2);
        check_value("id_funct3", inst[14:12], id_funct3);
        check_value("id_funct7", inst[31:25], id_funct7);
        check_value("id_imm", imm_for_format(inst), id_imm);
    endtask

    task automatic apb_readback();
        logic [31:0] r;
        logic [31:0] data;
        int          idx;
        int          written[$];
        start_test("apb_readback");
        run = 1'b0;
        for (int i = 0; i < 48; i++) begin
            r    = lcg_next();
            idx  = (r >> 16) % MEM_WORDS;
            data = lcg_next();
            apb_transfer(1'b1, idx * 4, data, r);
            model_mem[idx] = data;
            written.push_back(idx);
        end
        foreach (written[i]) begin
            apb_transfer(1'b0, written[i] * 4, 32'h0, data);
            check_value("prdata", model_mem[written[i]], data);
        end
        finish_test();
    endtask

    task automatic sequential_fetch();
        start_test("sequential_fetch");
        quiet_controls();
        run = 1'b1;
        for (int i = 0; i < 40; i++) begin
            clock_and_check();
        end
        finish_test();
    endtask

    // Branch codes alone or with random CSR requests on top
    task automatic redirects(input string name, input logic with_csr);
        logic [31:0] r;
        start_test(name);
        run = 1'b1;
        for (int i = 0; i < 48; i++) begin
            r           = lcg_next();
            branch_ctrl = r[31:30];
            zero        = r[29];
            csr_int     = with_csr && r[28];
            csr_mret    = with_csr && r[27];
            pc_imm      = lcg_next() & ~32'd3;
            pc_aluout   = lcg_next();
            csr_pc      = lcg_next() & ~32'd3;
            csr_retpc   = lcg_next() & ~32'd3;
            clock_and_check();
        end
        quiet_controls();
        finish_test();
    endtask

    task automatic stall_and_flush();
        logic [31:0] r;
        start_test("stall_and_flush");
        quiet_controls();
        run = 1'b1;
        for (int i = 0; i < 60; i++) begin
            r     = lcg_next();
            stall = (r[31:30] == 2'd0);
            flush = (r[29:28] == 2'd0);
            clock_and_check();
        end
        quiet_controls();
        finish_test();
    endtask

    task automatic immediate_formats();
        logic [31:0] r;
        logic [31:0] data;
        start_test("immediate_formats");
        run = 1'b0;
        for (int i = 0; i < 60; i++) begin
            data      = lcg_next();
            data[6:0] = opcode_at(i % 10);
            apb_transfer(1'b1, i * 4, data, r);
            model_mem[i] = data;
        end
        quiet_controls();
        run         = 1'b1;
        branch_ctrl = cpu_pkg::BRANCH_JAL;
        clock_and_check();
        branch_ctrl = cpu_pkg::BRANCH_NEXT;
        for (int i = 0; i < 62; i++) begin
            clock_and_check();
        end
        finish_test();
    endtask

    initial begin
        rng_state = 32'd45;
        tests_ok  = 0;
        tests_bad = 0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        run       = 1'b0;
        quiet_controls();
        model_pc = 32'h0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        for (int s = 0; s < 2; s++) begin
            pipe_pc[s]    = '0;
            pipe_inst[s]  = '0;
            pipe_valid[s] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        apb_readback();
        sequential_fetch();
        redirects("branch_redirect", 1'b0);
        redirects("csr_priority", 1'b1);
        stall_and_flush();
        immediate_formats();
        $display("tests ok %0d, tests with errors %0d, assertion failures %0d",
                 tests_ok, tests_bad, u_frontend_top.u_fetch.u_fetch_asserts.fail_count);
        if (tests_bad == 0 && u_frontend_top.u_fetch.u_fetch_asserts.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
